// File: hw/circle_pkg.sv
package circle_pkg;

    // Screen geometry
    localparam int screen_w = 160;
    localparam int screen_h = 120;

    // Input field widths
    localparam int x_w      = 8;
    localparam int y_w      = 7;
    localparam int radius_w = 8;
    localparam int colour_w = 3;

    // Signed working coordinates, wide enough for centre +/- radius
    localparam int coord_w  = 10;

    // Sequencer states
    typedef enum logic [1:0] {
        s_idle,
        s_clear,
        s_draw,
        s_done
    } circle_state_t;

endpackage

// File: hw/pixel_if.sv
`timescale 1ns/10ps

// One pixel write stream, valid/ready
interface pixel_if import circle_pkg::*; ();

    logic [x_w-1:0]      x;
    logic [y_w-1:0]      y;
    logic [colour_w-1:0] colour;
    logic                valid;
    logic                ready;

    modport source (
        output x, y, colour, valid,
        input  ready
    );

    modport sink (
        input  x, y, colour, valid,
        output ready
    );

endinterface

// File: hw/screen_clearer.sv
`timescale 1ns/10ps

module screen_clearer import circle_pkg::*; (
    input  logic    vif,
    input  logic    arst_n,
    input  logic    go,
    output logic    end_pulse,
    pixel_if.source px
);

    logic [x_w-1:0] x_cnt;
    logic [y_w-1:0] y_cnt;
    logic           busy;
    logic           fire;
    logic           last_x;
    logic           last_y;

    assign fire   = px.valid && px.ready;
    assign last_x = x_cnt == x_w'(screen_w - 1);
    assign last_y = y_cnt == y_w'(screen_h - 1);

    // High together with the transfer at the bottom right pixel
    assign end_pulse = fire && last_x && last_y;

    always_ff @(posedge vif or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (go) begin
            busy  <= 1'b1;
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (fire) begin
            if (last_x) begin
                x_cnt <= '0;
                if (last_y) begin
                    busy  <= 1'b0;
                    y_cnt <= '0;
                end else begin
                    y_cnt <= y_cnt + 1'b1;
                end
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    assign px.valid  = busy;
    assign px.x      = x_cnt;
    assign px.y      = y_cnt;
    assign px.colour = '0;

endmodule

// File: hw/octant_plotter.sv
`timescale 1ns/10ps

module octant_plotter import circle_pkg::*; (
    input  logic                vif,
    input  logic                arst_n,
    input  logic                go,
    input  logic [x_w-1:0]      cx,
    input  logic [y_w-1:0]      cy,
    input  logic [radius_w-1:0] r,
    output logic                end_pulse,
    pixel_if.source             px
);

    logic                      busy;
    logic [2:0]                oct;
    logic signed [coord_w-1:0] cx_r;
    logic signed [coord_w-1:0] cy_r;
    logic signed [coord_w-1:0] xs;
    logic signed [coord_w-1:0] ys;
    logic signed [coord_w:0]   d;
    logic signed [coord_w-1:0] x_nx;
    logic signed [coord_w-1:0] y_nx;
    logic signed [coord_w:0]   d_nx;
    logic signed [coord_w-1:0] cand_x;
    logic signed [coord_w-1:0] cand_y;
    logic                      on_screen;
    logic                      last_step;
    logic                      advance;

    // Midpoint update applied after the eighth point of a step
    always_comb begin
        y_nx = ys + coord_w'(1);
        if (d < 0) begin
            x_nx = xs;
            d_nx = d + {y_nx, 1'b1};
        end else begin
            x_nx = xs - coord_w'(1);
            d_nx = d + {y_nx - x_nx, 1'b1};
        end
    end

    assign last_step = y_nx > x_nx;

    // Fixed octant order
    always_comb begin
        case (oct)
            3'd0: begin cand_x = cx_r + xs; cand_y = cy_r + ys; end
            3'd1: begin cand_x = cx_r + ys; cand_y = cy_r + xs; end
            3'd2: begin cand_x = cx_r - ys; cand_y = cy_r + xs; end
            3'd3: begin cand_x = cx_r - xs; cand_y = cy_r + ys; end
            3'd4: begin cand_x = cx_r - xs; cand_y = cy_r - ys; end
            3'd5: begin cand_x = cx_r - ys; cand_y = cy_r - xs; end
            3'd6: begin cand_x = cx_r + ys; cand_y = cy_r - xs; end
            default: begin cand_x = cx_r + xs; cand_y = cy_r - ys; end
        endcase
    end

    assign on_screen = cand_x >= 0 && cand_x < screen_w &&
                       cand_y >= 0 && cand_y < screen_h;

    // Clipped points are dropped without waiting for ready
    assign advance   = busy && (!on_screen || px.ready);
    assign end_pulse = advance && oct == 3'd7 && last_step;

    always_ff @(posedge vif or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            oct  <= '0;
        end else if (go) begin
            busy <= 1'b1;
            oct  <= '0;
        end else if (advance) begin
            oct <= oct + 1'b1;
            if (end_pulse) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge vif) begin
        if (go) begin
            cx_r <= coord_w'(cx);
            cy_r <= coord_w'(cy);
            xs   <= coord_w'(r);
            ys   <= '0;
            d    <= (coord_w + 1)'(1) - (coord_w + 1)'(r);
        end else if (advance && oct == 3'd7) begin
            xs <= x_nx;
            ys <= y_nx;
            d  <= d_nx;
        end
    end

    assign px.valid  = busy && on_screen;
    assign px.x      = cand_x[x_w-1:0];
    assign px.y      = cand_y[y_w-1:0];
    // Draw colour is inserted by the sequencer
    assign px.colour = '0;

endmodule

// File: hw/circle_fsm.sv
`timescale 1ns/10ps

module circle_fsm import circle_pkg::*; (
    input  logic                vif,
    input  logic                arst_n,
    input  logic                start,
    input  logic [x_w-1:0]      centre_x,
    input  logic [y_w-1:0]      centre_y,
    input  logic [radius_w-1:0] radius,
    input  logic [colour_w-1:0] colour,
    output logic                done,
    pixel_if.sink               clear_px,
    pixel_if.sink               arc_px,
    output logic [x_w-1:0]      out_x,
    output logic [y_w-1:0]      out_y,
    output logic [colour_w-1:0] out_colour,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                clear_go,
    output logic                draw_go,
    input  logic                clear_end,
    input  logic                draw_end,
    output logic [x_w-1:0]      cx_q,
    output logic [y_w-1:0]      cy_q,
    output logic [radius_w-1:0] r_q,
    output logic [colour_w-1:0] colour_q
);

    circle_state_t state;
    circle_state_t state_nx;

    assign clear_go = state == s_idle && start;
    assign draw_go  = state == s_clear && clear_end;
    assign done     = state == s_done;

    always_comb begin
        state_nx = state;
        case (state)
            s_idle:  if (start) state_nx = s_clear;
            s_clear: if (clear_end) state_nx = s_draw;
            s_draw:  if (draw_end) state_nx = s_done;
            s_done:  if (!start) state_nx = s_idle;
            default: state_nx = s_idle;
        endcase
    end

    always_ff @(posedge vif or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
        end else begin
            state <= state_nx;
        end
    end

    // Request captured when the engine accepts start
    always_ff @(posedge vif) begin
        if (clear_go) begin
            cx_q     <= centre_x;
            cy_q     <= centre_y;
            r_q      <= radius;
            colour_q <= colour;
        end
    end

    // Only the active stream sees ready
    always_comb begin
        out_x          = clear_px.x;
        out_y          = clear_px.y;
        out_colour     = clear_px.colour;
        out_valid      = 1'b0;
        clear_px.ready = 1'b0;
        arc_px.ready   = 1'b0;
        case (state)
            s_clear: begin
                out_valid      = clear_px.valid;
                clear_px.ready = out_ready;
            end
            s_draw: begin
                out_x        = arc_px.x;
                out_y        = arc_px.y;
                out_colour   = colour_q;
                out_valid    = arc_px.valid;
                arc_px.ready = out_ready;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/circle_drawer.sv
`timescale 1ns/10ps

module circle_drawer import circle_pkg::*; (
    input  logic                vif,
    input  logic                arst_n,
    input  logic                start,
    input  logic [x_w-1:0]      centre_x,
    input  logic [y_w-1:0]      centre_y,
    input  logic [radius_w-1:0] radius,
    input  logic [colour_w-1:0] colour,
    output logic                done,
    output logic [x_w-1:0]      x,
    output logic [y_w-1:0]      y,
    output logic [colour_w-1:0] pixel_colour,
    output logic                plot,
    input  logic                plot_ready
);

    pixel_if clear_px ();
    pixel_if arc_px ();

    logic                clear_go;
    logic                draw_go;
    logic                clear_end;
    logic                draw_end;
    logic [x_w-1:0]      cx_q;
    logic [y_w-1:0]      cy_q;
    logic [radius_w-1:0] r_q;

    circle_fsm fsm_i (
        .vif        (vif),
        .arst_n     (arst_n),
        .start      (start),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .radius     (radius),
        .colour     (colour),
        .done       (done),
        .clear_px   (clear_px.sink),
        .arc_px     (arc_px.sink),
        .out_x      (x),
        .out_y      (y),
        .out_colour (pixel_colour),
        .out_valid  (plot),
        .out_ready  (plot_ready),
        .clear_go   (clear_go),
        .draw_go    (draw_go),
        .clear_end  (clear_end),
        .draw_end   (draw_end),
        .cx_q       (cx_q),
        .cy_q       (cy_q),
        .r_q        (r_q),
        .colour_q   ()
    );

    screen_clearer clearer_i (
        .vif       (vif),
        .arst_n    (arst_n),
        .go        (clear_go),
        .end_pulse (clear_end),
        .px        (clear_px.source)
    );

    octant_plotter plotter_i (
        .vif       (vif),
        .arst_n    (arst_n),
        .go        (draw_go),
        .cx        (cx_q),
        .cy        (cy_q),
        .r         (r_q),
        .end_pulse (draw_end),
        .px        (arc_px.source)
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic vif,
    output logic arst_n
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 16;

    initial begin
        vif = 1'b0;
        forever #(half_period) vif = ~vif;
    end

    // Reset released on a rising edge after 16 cycles
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge vif);
        arst_n <= 1'b1;
    end

endmodule

// File: test/circle_drawer_assert.sv
`timescale 1ns/10ps

module circle_drawer_assert import circle_pkg::*; (
    input logic                vif,
    input logic                arst_n,
    input circle_state_t       state,
    input logic                done,
    input logic                out_valid,
    input logic                out_ready,
    input logic [x_w-1:0]      out_x,
    input logic [y_w-1:0]      out_y,
    input logic [colour_w-1:0] out_colour
);

    int fail_cnt = 0;

    // Stalled pixel keeps its place until the sink takes it
    hold_until_accepted: assert property (
        @(posedge vif) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_x) && $stable(out_y)
            && $stable(out_colour)
    ) else begin
        fail_cnt++;
        $error("pixel stream dropped or changed a stalled pixel");
    end

    done_after_draw: assert property (
        @(posedge vif) disable iff (!arst_n)
        $rose(done) |-> $past(state) == s_draw
    ) else begin
        fail_cnt++;
        $error("done rose without coming from the draw state");
    end

    no_plot_in_reset: assert property (
        @(posedge vif) !arst_n |-> !out_valid
    ) else begin
        fail_cnt++;
        $error("pixel valid high during reset");
    end

endmodule

// File: test/circle_drawer_tb.sv
`timescale 1ns/10ps

module circle_drawer_tb import circle_pkg::*; ();

    localparam int n_pos       = 10;
    localparam int n_rad       = 6;
    localparam int n_fixed     = 3;
    localparam int n_cases     = n_pos * n_rad + n_fixed;
    localparam int n_clear     = screen_w * screen_h;
    localparam int hold_cyc    = 20;
    localparam int cycle_limit = n_cases * (n_clear + 8 * 256) * 4 + 100000;

    // Centre bins for inside, four corners, four edges and outside right
    localparam int pos_x[n_pos] = '{80, 0, 159, 0, 159, 80, 80, 0, 159, 200};
    localparam int pos_y[n_pos] = '{60, 0, 0, 119, 119, 0, 119, 60, 60, 60};
    // One radius from each range
    localparam int rad_v[n_rad] = '{5, 20, 45, 80, 150, 230};
    // Bit k set when radius k leaves pixels on screen
    localparam bit [5:0] drawn_mask[n_pos] = '{
        6'b001111, 6'b011111, 6'b011111, 6'b011111, 6'b011111,
        6'b001111, 6'b001111, 6'b011111, 6'b011111, 6'b011100
    };

    logic                vif;
    logic                arst_n;
    logic                start;
    logic [x_w-1:0]      centre_x;
    logic [y_w-1:0]      centre_y;
    logic [radius_w-1:0] radius;
    logic [colour_w-1:0] colour;
    logic                done;
    logic [x_w-1:0]      x;
    logic [y_w-1:0]      y;
    logic [colour_w-1:0] pixel_colour;
    logic                plot;
    logic                plot_ready = 1'b0;

    int          cx_tab[n_cases];
    int          cy_tab[n_cases];
    int          r_tab[n_cases];
    int          col_tab[n_cases];
    bit          drawn_tab[n_cases];
    int          pix_cnt[n_clear];
    int          model_total;
    int          clr_cnt;
    int          draw_cnt;
    int          cur_colour;
    bit          case_active;
    int          cycles = 0;
    logic [15:0] lfsr = 16'd5055;

    tb_clock_gen clk_i (
        .vif    (vif),
        .arst_n (arst_n)
    );

    circle_drawer dut_i (
        .vif          (vif),
        .arst_n       (arst_n),
        .start        (start),
        .centre_x     (centre_x),
        .centre_y     (centre_y),
        .radius       (radius),
        .colour       (colour),
        .done         (done),
        .x            (x),
        .y            (y),
        .pixel_colour (pixel_colour),
        .plot         (plot),
        .plot_ready   (plot_ready)
    );

    bind circle_fsm circle_drawer_assert assert_i (
        .vif        (vif),
        .arst_n     (arst_n),
        .state      (state),
        .done       (done),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_x      (out_x),
        .out_y      (out_y),
        .out_colour (out_colour)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic check_equal(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("[FAIL] %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic set_case(input int idx, input int cx, input int cy, input int r,
                            input int col, input bit drawn);
        cx_tab[idx]    = cx;
        cy_tab[idx]    = cy;
        r_tab[idx]     = r;
        col_tab[idx]   = col;
        drawn_tab[idx] = drawn;
    endtask

    task automatic fill_table();
        int k;
        k = 0;
        for (int p = 0; p < n_pos; p++) begin
            for (int q = 0; q < n_rad; q++) begin
                set_case(k, pos_x[p], pos_y[p], rad_v[q], k % 7 + 1, drawn_mask[p][q]);
                k++;
            end
        end
        set_case(k, 255, 127, 0, 6, 1'b0);
        set_case(k + 1, 255, 127, 255, 7, 1'b1);
        set_case(k + 2, 80, 60, 0, 3, 1'b1);
    endtask

    task automatic add_point(input int px, input int py);
        if (px >= 0 && px < screen_w && py >= 0 && py < screen_h) begin
            pix_cnt[py * screen_w + px]++;
            model_total++;
        end
    endtask

    // Midpoint circle over a count bitmap with duplicates kept
    task automatic build_model(input int cx, input int cy, input int r);
        int mx;
        int my;
        int d;
        foreach (pix_cnt[i]) begin
            pix_cnt[i] = 0;
        end
        model_total = 0;
        mx = r;
        my = 0;
        d = 1 - r;
        while (my <= mx) begin
            add_point(cx + mx, cy + my);
            add_point(cx + my, cy + mx);
            add_point(cx - my, cy + mx);
            add_point(cx - mx, cy + my);
            add_point(cx - mx, cy - my);
            add_point(cx - my, cy - mx);
            add_point(cx + my, cy - mx);
            add_point(cx + mx, cy - my);
            my++;
            if (d < 0) begin
                d += 2 * my + 1;
            end else begin
                mx--;
                d += 2 * (my - mx) + 1;
            end
        end
    endtask

    task automatic run_case(input int i);
        build_model(cx_tab[i], cy_tab[i], r_tab[i]);
        clr_cnt = 0;
        draw_cnt = 0;
        cur_colour = col_tab[i];
        @(posedge vif);
        case_active = 1'b1;
        start    <= 1'b1;
        centre_x <= x_w'(cx_tab[i]);
        centre_y <= y_w'(cy_tab[i]);
        radius   <= radius_w'(r_tab[i]);
        colour   <= colour_w'(col_tab[i]);
        // Inputs cleared once the request is captured
        repeat (2) @(posedge vif);
        centre_x <= '0;
        centre_y <= '0;
        radius   <= '0;
        colour   <= '0;
        while (!done) begin
            @(negedge vif);
        end
        check_equal("clear transfers at done", clr_cnt, n_clear);
        check_equal("draw transfers at done", draw_cnt, model_total);
        check_equal("circle has on-screen pixels", int'(draw_cnt > 0), int'(drawn_tab[i]));
        repeat (hold_cyc) begin
            @(negedge vif);
            check_equal("done held while start high", int'(done), 1);
            check_equal("no restart while start high", int'(plot), 0);
        end
        @(posedge vif);
        start <= 1'b0;
        @(posedge vif);
        @(negedge vif);
        check_equal("done low after start falls", int'(done), 0);
        check_equal("bound assertion failures", dut_i.fsm_i.assert_i.fail_cnt, 0);
        case_active = 1'b0;
    endtask

    always @(posedge vif) begin
        logic b0;
        logic b1;
        lfsr = lfsr_step(lfsr);
        b0 = lfsr[0];
        lfsr = lfsr_step(lfsr);
        b1 = lfsr[0];
        // Ready about three cycles in four
        plot_ready <= b0 | b1;
    end

    always @(posedge vif) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    // Transfers sampled mid-cycle and taken at the next rising edge
    always @(negedge vif) begin
        int idx;
        if (!arst_n) begin
            check_equal("plot low in reset", int'(plot), 0);
            check_equal("done low in reset", int'(done), 0);
        end else if (plot && plot_ready) begin
            check_equal("transfer only after start", int'(case_active), 1);
            if (clr_cnt < n_clear) begin
                check_equal("clear x", int'(x), clr_cnt % screen_w);
                check_equal("clear y", int'(y), clr_cnt / screen_w);
                check_equal("clear colour", int'(pixel_colour), 0);
                clr_cnt++;
            end else begin
                check_equal("draw x on screen", int'(int'(x) < screen_w), 1);
                check_equal("draw y on screen", int'(int'(y) < screen_h), 1);
                check_equal("draw colour", int'(pixel_colour), cur_colour);
                idx = int'(y) * screen_w + int'(x);
                check_equal("draw pixel in model set", int'(pix_cnt[idx] > 0), 1);
                pix_cnt[idx]--;
                draw_cnt++;
            end
        end else if (!case_active) begin
            check_equal("done low while idle", int'(done), 0);
        end
    end

    initial begin
        start       = 1'b0;
        centre_x    = '0;
        centre_y    = '0;
        radius      = '0;
        colour      = '0;
        case_active = 1'b0;
        fill_table();
        @(posedge arst_n);
        repeat (8) @(posedge vif);
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: circle_drawer.f
hw/circle_pkg.sv
hw/pixel_if.sv
hw/screen_clearer.sv
hw/octant_plotter.sv
hw/circle_fsm.sv
hw/circle_drawer.sv
test/tb_clock_gen.sv
test/circle_drawer_assert.sv
test/circle_drawer_tb.sv

// File: Makefile
TOP := circle_drawer_tb
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f circle_drawer.f -o sim_bin
	./obj_dir/sim_bin | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	verilator --lint-only --top-module circle_drawer \
		hw/circle_pkg.sv hw/pixel_if.sv hw/screen_clearer.sv \
		hw/octant_plotter.sv hw/circle_fsm.sv hw/circle_drawer.sv

clean:
	rm -rf obj_dir $(LOG)
